// File: verilog/trdb_pkg.sv
// Trace debugger shared definitions
`default_nettype none

package trdb_pkg;

    localparam int unsigned XLEN         = 32;
    localparam int unsigned CAUSE_LEN    = 5;
    localparam int unsigned PRIV_LEN     = 2;
    localparam int unsigned BMAP_LEN     = 8;
    localparam int unsigned BCNT_LEN     = 4;
    localparam int unsigned FIFO_DEPTH   = 4;
    localparam int unsigned FIFO_PTR_LEN = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CNT_LEN = FIFO_PTR_LEN + 1;

    localparam logic [PRIV_LEN-1:0] PRIV_M = 2'd3;

    // conditional branches, including the pulp immediate compares
    localparam logic [XLEN-1:0] MASK_BEQ       = 32'h0000707f;
    localparam logic [XLEN-1:0] MATCH_BEQ      = 32'h00000063;
    localparam logic [XLEN-1:0] MASK_BNE       = 32'h0000707f;
    localparam logic [XLEN-1:0] MATCH_BNE      = 32'h00001063;
    localparam logic [XLEN-1:0] MASK_BLT       = 32'h0000707f;
    localparam logic [XLEN-1:0] MATCH_BLT      = 32'h00004063;
    localparam logic [XLEN-1:0] MASK_BGE       = 32'h0000707f;
    localparam logic [XLEN-1:0] MATCH_BGE      = 32'h00005063;
    localparam logic [XLEN-1:0] MASK_BLTU      = 32'h0000707f;
    localparam logic [XLEN-1:0] MATCH_BLTU     = 32'h00006063;
    localparam logic [XLEN-1:0] MASK_BGEU      = 32'h0000707f;
    localparam logic [XLEN-1:0] MATCH_BGEU     = 32'h00007063;
    localparam logic [XLEN-1:0] MASK_P_BNEIMM  = 32'h0000707f;
    localparam logic [XLEN-1:0] MATCH_P_BNEIMM = 32'h00003063;
    localparam logic [XLEN-1:0] MASK_P_BEQIMM  = 32'h0000707f;
    localparam logic [XLEN-1:0] MATCH_P_BEQIMM = 32'h00002063;

    // unpredictable discontinuities
    localparam logic [XLEN-1:0] MASK_JALR  = 32'h0000707f;
    localparam logic [XLEN-1:0] MATCH_JALR = 32'h00000067;
    localparam logic [XLEN-1:0] MASK_MRET  = 32'hffffffff;
    localparam logic [XLEN-1:0] MATCH_MRET = 32'h30200073;
    localparam logic [XLEN-1:0] MASK_SRET  = 32'hffffffff;
    localparam logic [XLEN-1:0] MATCH_SRET = 32'h10200073;
    localparam logic [XLEN-1:0] MASK_URET  = 32'hffffffff;
    localparam logic [XLEN-1:0] MATCH_URET = 32'h00200073;

    localparam logic [XLEN-1:0] ADDR_CTRL   = 32'h0;
    localparam logic [XLEN-1:0] ADDR_STATUS = 32'h4;

    typedef enum logic [1:0] {
        PKT_NONE,
        PKT_BRANCH_FULL,
        PKT_ADDR,
        PKT_EXCEPTION
    } trdb_format_e;

    typedef enum logic [1:0] {
        CLS_OTHER,
        CLS_BRANCH,
        CLS_UDISC
    } instr_class_e;

    typedef struct packed {
        logic                 valid;
        logic                 exception;
        logic                 interrupt;
        logic [CAUSE_LEN-1:0] cause;
        logic [PRIV_LEN-1:0]  priv;
        logic [XLEN-1:0]      iaddr;
        logic [XLEN-1:0]      instr;
        logic                 compressed;
    } trdb_instr_t;

    typedef struct packed {
        logic [XLEN-1:0]      iaddr;
        logic [PRIV_LEN-1:0]  priv;
        logic [CAUSE_LEN-1:0] cause;
        logic                 interrupt;
        logic                 exception;
        instr_class_e         cls;
        logic                 taken;
        logic                 privchange;
        logic                 after_exc;
        logic                 after_udisc;
        logic                 first;
    } trdb_decoded_t;

    typedef struct packed {
        trdb_format_e         format;
        logic [BCNT_LEN-1:0]  bcnt;
        logic                 interrupt;
        logic [CAUSE_LEN-1:0] cause;
        logic [PRIV_LEN-1:0]  priv;
        logic [9:0]           zero;
        logic [BMAP_LEN-1:0]  bmap;
    } trdb_header_t;

    typedef struct packed {
        trdb_header_t    header;
        logic [XLEN-1:0] addr;
        logic            has_addr;
    } trdb_packet_t;

    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [XLEN-1:0] paddr;
        logic [XLEN-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: verilog/trdb_decode.sv
// Retire record decode stage
`timescale 1ns/1ps
`default_nettype none

module trdb_decode (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  trdb_pkg::trdb_instr_t   instr_i,
    input  logic                    trace_en_i,
    output logic                    tc_valid_o,
    output trdb_pkg::trdb_decoded_t tc_o
);

    trdb_pkg::trdb_instr_t   instr_q;
    trdb_pkg::trdb_instr_t   held_q;
    trdb_pkg::instr_class_e  cls;
    trdb_pkg::instr_class_e  held_cls_q;
    trdb_pkg::trdb_decoded_t tc_d;

    logic                      trace_en_q;
    logic                      qualified;
    logic                      resolve;
    logic                      held_valid_q;
    logic                      held_first_q;
    logic                      held_after_exc_q;
    logic                      held_after_udisc_q;
    logic [trdb_pkg::XLEN-1:0] next_seq;

    function automatic logic hit(input logic [trdb_pkg::XLEN-1:0] word,
                                 input logic [trdb_pkg::XLEN-1:0] mask,
                                 input logic [trdb_pkg::XLEN-1:0] match);
        return (word & mask) == match;
    endfunction

    always_comb begin
        cls = trdb_pkg::CLS_OTHER;
        if (hit(instr_q.instr, trdb_pkg::MASK_BEQ, trdb_pkg::MATCH_BEQ) ||
            hit(instr_q.instr, trdb_pkg::MASK_BNE, trdb_pkg::MATCH_BNE) ||
            hit(instr_q.instr, trdb_pkg::MASK_BLT, trdb_pkg::MATCH_BLT) ||
            hit(instr_q.instr, trdb_pkg::MASK_BGE, trdb_pkg::MATCH_BGE) ||
            hit(instr_q.instr, trdb_pkg::MASK_BLTU, trdb_pkg::MATCH_BLTU) ||
            hit(instr_q.instr, trdb_pkg::MASK_BGEU, trdb_pkg::MATCH_BGEU) ||
            hit(instr_q.instr, trdb_pkg::MASK_P_BNEIMM, trdb_pkg::MATCH_P_BNEIMM) ||
            hit(instr_q.instr, trdb_pkg::MASK_P_BEQIMM, trdb_pkg::MATCH_P_BEQIMM)) begin
            cls = trdb_pkg::CLS_BRANCH;
        end else if (hit(instr_q.instr, trdb_pkg::MASK_JALR, trdb_pkg::MATCH_JALR) ||
                     hit(instr_q.instr, trdb_pkg::MASK_MRET, trdb_pkg::MATCH_MRET) ||
                     hit(instr_q.instr, trdb_pkg::MASK_SRET, trdb_pkg::MATCH_SRET) ||
                     hit(instr_q.instr, trdb_pkg::MASK_URET, trdb_pkg::MATCH_URET)) begin
            cls = trdb_pkg::CLS_UDISC;
        end
    end

    // only machine mode is traced
    assign qualified = instr_q.valid && trace_en_q && (instr_q.priv == trdb_pkg::PRIV_M);
    assign resolve   = qualified && held_valid_q;
    assign next_seq  = held_q.iaddr + (held_q.compressed ? 32'd2 : 32'd4);

    // the new record decides the outcome of the held one
    always_comb begin
        tc_d.iaddr       = held_q.iaddr;
        tc_d.priv        = held_q.priv;
        tc_d.cause       = held_q.cause;
        tc_d.interrupt   = held_q.interrupt;
        tc_d.exception   = held_q.exception;
        tc_d.cls         = held_cls_q;
        tc_d.taken       = instr_q.iaddr != next_seq;
        tc_d.privchange  = held_q.priv != instr_q.priv;
        tc_d.after_exc   = held_after_exc_q;
        tc_d.after_udisc = held_after_udisc_q;
        tc_d.first       = held_first_q;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_q            <= '0;
            trace_en_q         <= 1'b0;
            tc_valid_o         <= 1'b0;
            held_valid_q       <= 1'b0;
            held_first_q       <= 1'b0;
            held_after_exc_q   <= 1'b0;
            held_after_udisc_q <= 1'b0;
        end else begin
            instr_q    <= instr_i;
            trace_en_q <= trace_en_i;
            tc_valid_o <= resolve;
            if (qualified) begin
                held_valid_q       <= 1'b1;
                held_first_q       <= !held_valid_q;
                held_after_exc_q   <= held_valid_q && held_q.exception;
                held_after_udisc_q <= held_valid_q && (held_cls_q == trdb_pkg::CLS_UDISC);
            end else if (!trace_en_q || instr_q.valid) begin
                // leaving the traced state restarts with a first instruction
                held_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (qualified) begin
            held_q     <= instr_q;
            held_cls_q <= cls;
        end
        if (resolve) begin
            tc_o <= tc_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/trdb_branch_map.sv
// Branch outcome map
`timescale 1ns/1ps
`default_nettype none

module trdb_branch_map (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          push_i,
    input  logic                          taken_i,
    input  logic                          flush_i,
    output logic [trdb_pkg::BMAP_LEN-1:0] map_o,
    output logic [trdb_pkg::BCNT_LEN-1:0] count_o
);

    logic [trdb_pkg::BMAP_LEN-1:0] map_q;
    logic [trdb_pkg::BCNT_LEN-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // a push on flush starts the new map
            map_q      <= '0;
            map_q[0]   <= push_i && taken_i;
            count_q    <= '0;
            count_q[0] <= push_i;
        end else if (push_i) begin
            // oldest branch sits in bit 0
            map_q[count_q[trdb_pkg::BCNT_LEN-2:0]] <= taken_i;
            count_q                                <= count_q + 1'b1;
        end
    end

    assign map_o   = map_q;
    assign count_o = count_q;

endmodule

`default_nettype wire

// File: verilog/trdb_priority.sv
// Packet decision logic
`timescale 1ns/1ps
`default_nettype none

module trdb_priority (
    input  logic                          tc_valid_i,
    input  trdb_pkg::trdb_decoded_t       tc_i,
    input  logic [trdb_pkg::BMAP_LEN-1:0] map_i,
    input  logic [trdb_pkg::BCNT_LEN-1:0] count_i,
    output logic                          bmap_push_o,
    output logic                          bmap_flush_o,
    output logic                          pkt_valid_o,
    output trdb_pkg::trdb_packet_t        pkt_o
);

    trdb_pkg::trdb_format_e        format;
    logic                          is_branch;
    logic                          need_addr;
    logic [trdb_pkg::BMAP_LEN-1:0] hdr_map;
    logic [trdb_pkg::BCNT_LEN-1:0] hdr_cnt;

    assign is_branch = tc_valid_i && (tc_i.cls == trdb_pkg::CLS_BRANCH);
    assign need_addr = tc_i.first || tc_i.after_exc || tc_i.after_udisc || tc_i.privchange;

    // the header already sees this instruction's own branch
    always_comb begin
        hdr_map = map_i;
        hdr_cnt = count_i;
        if (is_branch) begin
            hdr_map[count_i[trdb_pkg::BCNT_LEN-2:0]] = tc_i.taken;
            hdr_cnt                                  = count_i + 1'b1;
        end
    end

    always_comb begin
        format = trdb_pkg::PKT_NONE;
        if (tc_valid_i) begin
            if (tc_i.exception) begin
                format = trdb_pkg::PKT_EXCEPTION;
            end else if (need_addr) begin
                format = trdb_pkg::PKT_ADDR;
            end else if (is_branch && (32'(hdr_cnt) == trdb_pkg::BMAP_LEN)) begin
                format = trdb_pkg::PKT_BRANCH_FULL;
            end
        end
    end

    assign pkt_valid_o  = format != trdb_pkg::PKT_NONE;
    assign bmap_flush_o = pkt_valid_o;
    // when a packet goes out the branch is already part of its header
    assign bmap_push_o  = is_branch && !pkt_valid_o;

    always_comb begin
        pkt_o.header.format    = format;
        pkt_o.header.bcnt      = hdr_cnt;
        pkt_o.header.interrupt = (format == trdb_pkg::PKT_EXCEPTION) && tc_i.interrupt;
        pkt_o.header.cause     = (format == trdb_pkg::PKT_EXCEPTION) ? tc_i.cause : '0;
        pkt_o.header.priv      = tc_i.priv;
        pkt_o.header.zero      = '0;
        pkt_o.header.bmap      = hdr_map;
        pkt_o.addr             = tc_i.iaddr;
        pkt_o.has_addr         = format != trdb_pkg::PKT_BRANCH_FULL;
    end

endmodule

`default_nettype wire

// File: verilog/trdb_packet_emitter.sv
// Packet word FIFO
`timescale 1ns/1ps
`default_nettype none

module trdb_packet_emitter (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      pkt_valid_i,
    input  trdb_pkg::trdb_packet_t    pkt_i,
    output logic [trdb_pkg::XLEN-1:0] packet_word_o,
    output logic                      packet_word_valid_o,
    input  logic                      packet_ready_i,
    output logic                      overflow_o
);

    trdb_pkg::trdb_packet_t pkt_q;
    logic                   pkt_valid_q;

    logic [trdb_pkg::XLEN-1:0]         mem_q [trdb_pkg::FIFO_DEPTH];
    logic [trdb_pkg::FIFO_PTR_LEN-1:0] wr_ptr_q;
    logic [trdb_pkg::FIFO_PTR_LEN-1:0] rd_ptr_q;
    logic [trdb_pkg::FIFO_CNT_LEN-1:0] count_q;
    logic [trdb_pkg::FIFO_CNT_LEN-1:0] n_push;
    logic [trdb_pkg::FIFO_CNT_LEN-1:0] n_pop;
    logic                              fits;
    logic                              push;
    logic                              pop;

    // whole packets only, one or two slots
    assign fits = (32'(count_q) + (pkt_q.has_addr ? 32'd2 : 32'd1)) <= trdb_pkg::FIFO_DEPTH;
    assign push = pkt_valid_q && fits;
    assign pop  = packet_word_valid_o && packet_ready_i;

    assign n_push = push ? {{(trdb_pkg::FIFO_CNT_LEN-2){1'b0}}, pkt_q.has_addr, !pkt_q.has_addr}
                         : '0;
    assign n_pop  = {{(trdb_pkg::FIFO_CNT_LEN-1){1'b0}}, pop};

    assign overflow_o          = pkt_valid_q && !fits;
    assign packet_word_valid_o = count_q != '0;
    assign packet_word_o       = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pkt_valid_q <= 1'b0;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
        end else begin
            pkt_valid_q <= pkt_valid_i;
            wr_ptr_q    <= wr_ptr_q + n_push[trdb_pkg::FIFO_PTR_LEN-1:0];
            rd_ptr_q    <= rd_ptr_q + n_pop[trdb_pkg::FIFO_PTR_LEN-1:0];
            count_q     <= count_q + n_push - n_pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pkt_valid_i) begin
            pkt_q <= pkt_i;
        end
        if (push) begin
            mem_q[wr_ptr_q] <= pkt_q.header;
            if (pkt_q.has_addr) begin
                mem_q[wr_ptr_q + 1'b1] <= pkt_q.addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/trdb_apb_regs.sv
// APB configuration registers
`timescale 1ns/1ps
`default_nettype none

module trdb_apb_regs (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  trdb_pkg::apb_req_t apb_req_i,
    output trdb_pkg::apb_rsp_t apb_rsp_o,
    input  logic               overflow_i,
    output logic               trace_en_o
);

    logic access;
    logic wr;
    logic ctrl_sel;
    logic status_sel;
    logic trace_en_q;
    logic overflow_q;

    // transfers complete in the access phase
    assign access     = apb_req_i.psel && apb_req_i.penable;
    assign wr         = access && apb_req_i.pwrite;
    assign ctrl_sel   = apb_req_i.paddr == trdb_pkg::ADDR_CTRL;
    assign status_sel = apb_req_i.paddr == trdb_pkg::ADDR_STATUS;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            trace_en_q <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            if (wr && ctrl_sel) begin
                trace_en_q <= apb_req_i.pwdata[0];
            end
            // a new loss wins over a clear in the same cycle
            if (overflow_i) begin
                overflow_q <= 1'b1;
            end else if (wr && status_sel && apb_req_i.pwdata[0]) begin
                overflow_q <= 1'b0;
            end
        end
    end

    always_comb begin
        apb_rsp_o.prdata = '0;
        if (ctrl_sel) begin
            apb_rsp_o.prdata[0] = trace_en_q;
        end else if (status_sel) begin
            apb_rsp_o.prdata[0] = overflow_q;
        end
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = access && !ctrl_sel && !status_sel;
    end

    assign trace_en_o = trace_en_q;

endmodule

`default_nettype wire

// File: verilog/trace_debugger.sv
// Trace debugger top level
`timescale 1ns/1ps
`default_nettype none

module trace_debugger (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  trdb_pkg::trdb_instr_t     instr_i,
    input  trdb_pkg::apb_req_t        apb_req_i,
    output trdb_pkg::apb_rsp_t        apb_rsp_o,
    output logic [trdb_pkg::XLEN-1:0] packet_word_o,
    output logic                      packet_word_valid_o,
    input  logic                      packet_ready_i
);

    trdb_pkg::trdb_decoded_t       tc;
    trdb_pkg::trdb_packet_t        pkt;
    logic                          tc_valid;
    logic                          pkt_valid;
    logic                          trace_en;
    logic                          overflow_pulse;
    logic                          bmap_push;
    logic                          bmap_flush;
    logic [trdb_pkg::BMAP_LEN-1:0] bmap;
    logic [trdb_pkg::BCNT_LEN-1:0] bcnt;

    trdb_decode i_trdb_decode (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .instr_i    (instr_i),
        .trace_en_i (trace_en),
        .tc_valid_o (tc_valid),
        .tc_o       (tc)
    );

    // execute stage, packet choice plus branch history
    trdb_priority i_trdb_priority (
        .tc_valid_i   (tc_valid),
        .tc_i         (tc),
        .map_i        (bmap),
        .count_i      (bcnt),
        .bmap_push_o  (bmap_push),
        .bmap_flush_o (bmap_flush),
        .pkt_valid_o  (pkt_valid),
        .pkt_o        (pkt)
    );

    trdb_branch_map i_trdb_branch_map (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (bmap_push),
        .taken_i (tc.taken),
        .flush_i (bmap_flush),
        .map_o   (bmap),
        .count_o (bcnt)
    );

    trdb_packet_emitter i_trdb_packet_emitter (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .pkt_valid_i         (pkt_valid),
        .pkt_i               (pkt),
        .packet_word_o       (packet_word_o),
        .packet_word_valid_o (packet_word_valid_o),
        .packet_ready_i      (packet_ready_i),
        .overflow_o          (overflow_pulse)
    );

    trdb_apb_regs i_trdb_apb_regs (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .apb_req_i  (apb_req_i),
        .apb_rsp_o  (apb_rsp_o),
        .overflow_i (overflow_pulse),
        .trace_en_o (trace_en)
    );

endmodule

`default_nettype wire

// File: tests/trace_debugger_assertions.sv
// Trace debugger bound assertions
`timescale 1ns/1ps
`default_nettype none

module trace_debugger_assertions (
    input logic                      clk_i,
    input logic                      rst_ni,
    input trdb_pkg::apb_req_t        apb_req_i,
    input trdb_pkg::apb_rsp_t        apb_rsp_i,
    input logic                      pkt_valid_i,
    input trdb_pkg::trdb_packet_t    pkt_i,
    input logic [trdb_pkg::XLEN-1:0] word_i,
    input logic                      word_valid_i,
    input logic                      ready_i
);

    logic unmapped;

    assign unmapped = (apb_req_i.paddr != trdb_pkg::ADDR_CTRL) &&
                      (apb_req_i.paddr != trdb_pkg::ADDR_STATUS);

    // an offered word waits for the sink
    word_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (word_valid_i && !ready_i) |=> (word_valid_i && $stable(word_i)))
        else $error("packet word changed or vanished while the sink stalled");

    full_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (pkt_valid_i && (pkt_i.header.format == trdb_pkg::PKT_BRANCH_FULL)) |->
        (32'(pkt_i.header.bcnt) == trdb_pkg::BMAP_LEN))
        else $error("branch-full header with a count other than the map length");

    slverr_unmapped: assert property (@(posedge clk_i) disable iff (!rst_ni)
        apb_rsp_i.pslverr |-> (apb_req_i.psel && apb_req_i.penable && unmapped))
        else $error("pslverr raised for a mapped address or outside an access");

endmodule

bind trace_debugger trace_debugger_assertions i_trace_debugger_assertions (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .apb_req_i    (apb_req_i),
    .apb_rsp_i    (apb_rsp_o),
    .pkt_valid_i  (pkt_valid),
    .pkt_i        (pkt),
    .word_i       (packet_word_o),
    .word_valid_i (packet_word_valid_o),
    .ready_i      (packet_ready_i)
);

`default_nettype wire

// File: tests/tb_trace_debugger.sv
// Trace debugger testbench
`timescale 1ns/1ps
`default_nettype none

module tb_trace_debugger;

    localparam int CLK_PERIOD = 10;
    localparam int WORD_WAIT  = 50;
    localparam int APB_WAIT   = 8;

    // rough run length: records take 2 cycles, APB transfers 3, words up to WORD_WAIT
    localparam int RECORDS         = 60;
    localparam int APB_XFERS       = 30;
    localparam int WORDS           = 24;
    localparam int WATCHDOG_CYCLES = 4 * (RECORDS * 2 + APB_XFERS * 3 + WORDS * WORD_WAIT + 100);

    localparam logic [31:0] NOP  = 32'h00000013;
    localparam logic [31:0] BEQ  = 32'h00208463;
    localparam logic [31:0] BNE  = 32'h00209463;
    localparam logic [31:0] JALR = 32'h00008067;

    logic                  clk_i;
    logic                  rst_ni;
    trdb_pkg::trdb_instr_t instr_i;
    trdb_pkg::apb_req_t    apb_req_i;
    trdb_pkg::apb_rsp_t    apb_rsp_o;
    logic [31:0]           packet_word_o;
    logic                  packet_word_valid_o;
    logic                  packet_ready_i;

    int     errors;
    int     checks;
    integer seed;

    trace_debugger i_trace_debugger (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .instr_i             (instr_i),
        .apb_req_i           (apb_req_i),
        .apb_rsp_o           (apb_rsp_o),
        .packet_word_o       (packet_word_o),
        .packet_word_valid_o (packet_word_valid_o),
        .packet_ready_i      (packet_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // first packet word, laid out as format/count/irq/cause/priv/zero/map
    function automatic logic [31:0] header_word(input trdb_pkg::trdb_format_e fmt,
                                                input logic [3:0] cnt,
                                                input logic [4:0] cause,
                                                input logic [7:0] map);
        return {fmt, cnt, 1'b0, cause, trdb_pkg::PRIV_M, 10'b0, map};
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic apb_xfer(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        int waited;
        waited = 0;
        @(posedge clk_i);
        apb_req_i.psel    <= 1'b1;
        apb_req_i.penable <= 1'b0;
        apb_req_i.pwrite  <= write;
        apb_req_i.paddr   <= addr;
        apb_req_i.pwdata  <= wdata;
        @(posedge clk_i);
        apb_req_i.penable <= 1'b1;
        @(negedge clk_i);
        while (!apb_rsp_o.pready && waited < APB_WAIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!apb_rsp_o.pready) begin
            errors++;
            $display("%0t ns: APB transfer to %h never saw pready", $time, addr);
        end
        rdata = apb_rsp_o.prdata;
        err   = apb_rsp_o.pslverr;
        @(posedge clk_i);
        apb_req_i <= '0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        compare("pslverr on write", {31'b0, err}, 32'h0);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        apb_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    // one retired instruction, then an idle cycle
    task automatic retire(input logic [31:0] addr, input logic [31:0] instr, input logic exc,
                          input logic [4:0] cause, input logic [1:0] priv);
        trdb_pkg::trdb_instr_t rec;
        rec            = '0;
        rec.valid      = 1'b1;
        rec.exception  = exc;
        rec.cause      = cause;
        rec.priv       = priv;
        rec.iaddr      = addr;
        rec.instr      = instr;
        @(posedge clk_i);
        instr_i <= rec;
        @(posedge clk_i);
        instr_i <= '0;
    endtask

    task automatic expect_word(input logic [31:0] exp, input string label);
        int waited;
        waited = 0;
        @(posedge clk_i);
        packet_ready_i <= 1'b1;
        @(negedge clk_i);
        while (!packet_word_valid_o && waited < WORD_WAIT) begin
            @(negedge clk_i);
            waited++;
        end
        checks++;
        if (!packet_word_valid_o) begin
            errors++;
            $display("%0t ns: no packet word arrived within %0d cycles (%s)",
                     $time, WORD_WAIT, label);
        end else if (packet_word_o !== exp) begin
            errors++;
            $display("[ERROR] %0t ns packet_word_o (%s): expected %h, got %h",
                     $time, label, exp, packet_word_o);
        end
        @(posedge clk_i);
        packet_ready_i <= 1'b0;
    endtask

    task automatic expect_silence(input int cycles);
        int seen;
        seen = 0;
        repeat (cycles) begin
            @(negedge clk_i);
            if (packet_word_valid_o) begin
                seen++;
            end
        end
        checks++;
        if (seen != 0) begin
            errors++;
            $display("%0t ns: a packet word was offered when none was due", $time);
        end
    endtask

    // a short disable drops the held instruction
    task automatic restart_trace();
        apb_write(trdb_pkg::ADDR_CTRL, 32'h0);
        apb_write(trdb_pkg::ADDR_CTRL, 32'h1);
    endtask

    task automatic registers_access();
        logic [31:0] rdata;
        logic        err;
        apb_write(trdb_pkg::ADDR_CTRL, 32'h1);
        apb_read(trdb_pkg::ADDR_CTRL, rdata, err);
        compare("prdata CTRL", rdata, 32'h1);
        compare("pslverr CTRL", {31'b0, err}, 32'h0);
        apb_read(trdb_pkg::ADDR_STATUS, rdata, err);
        compare("prdata STATUS", rdata, 32'h0);
        apb_read(32'h10, rdata, err);
        compare("pslverr unmapped", {31'b0, err}, 32'h1);
        compare("prdata unmapped", rdata, 32'h0);
        apb_write(trdb_pkg::ADDR_CTRL, 32'h0);
    endtask

    task automatic tracing_disabled();
        retire(32'h0800, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h0804, BEQ, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h0900, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        expect_silence(12);
        // enabled, but supervisor mode is not traced
        apb_write(trdb_pkg::ADDR_CTRL, 32'h1);
        retire(32'h0800, NOP, 1'b0, 5'd0, 2'd1);
        retire(32'h0804, BEQ, 1'b0, 5'd0, 2'd1);
        retire(32'h0900, NOP, 1'b0, 5'd0, 2'd1);
        expect_silence(12);
    endtask

    task automatic first_instruction();
        restart_trace();
        retire(32'h1000, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h1004, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        expect_word(header_word(trdb_pkg::PKT_ADDR, 4'd0, 5'd0, 8'h00), "first header");
        expect_word(32'h1000, "first address");
        expect_silence(8);
    endtask

    task automatic branch_full();
        logic [31:0] addr;
        logic [31:0] next_addr;
        logic [31:0] rnd;
        logic [7:0]  exp_map;
        restart_trace();
        retire(32'h2000, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        addr    = 32'h2004;
        exp_map = 8'h00;
        for (int i = 0; i < 8; i++) begin
            rnd        = $random(seed);
            exp_map[i] = rnd[0];
            next_addr  = rnd[0] ? addr + 32'h40 : addr + 32'h4;
            retire(addr, BEQ, 1'b0, 5'd0, trdb_pkg::PRIV_M);
            addr = next_addr;
        end
        retire(addr, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        expect_word(header_word(trdb_pkg::PKT_ADDR, 4'd0, 5'd0, 8'h00), "trace start header");
        expect_word(32'h2000, "trace start address");
        expect_word(header_word(trdb_pkg::PKT_BRANCH_FULL, 4'd8, 5'd0, exp_map),
                    "branch-full header");
        expect_silence(8);
    endtask

    task automatic discontinuity_exception();
        restart_trace();
        retire(32'h3000, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h3004, BEQ, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h3040, BNE, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        expect_word(header_word(trdb_pkg::PKT_ADDR, 4'd0, 5'd0, 8'h00), "start header");
        expect_word(32'h3000, "start address");
        retire(32'h3044, JALR, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h3800, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h3804, NOP, 1'b1, 5'd2, trdb_pkg::PRIV_M);
        // taken beq then not-taken bne are pending at the jalr target
        expect_word(header_word(trdb_pkg::PKT_ADDR, 4'd2, 5'd0, 8'b0000_0001),
                    "jalr target header");
        expect_word(32'h3800, "jalr target address");
        retire(32'h0100, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        expect_word(header_word(trdb_pkg::PKT_EXCEPTION, 4'd0, 5'd2, 8'h00),
                    "exception header");
        expect_word(32'h3804, "exception address");
        retire(32'h0104, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        expect_word(header_word(trdb_pkg::PKT_ADDR, 4'd0, 5'd0, 8'h00), "handler header");
        expect_word(32'h0100, "handler address");
    endtask

    task automatic backpressure_overflow();
        logic [31:0] rdata;
        logic        err;
        restart_trace();
        retire(32'h4000, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h4004, JALR, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h4200, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h4204, JALR, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h4400, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        retire(32'h4404, NOP, 1'b0, 5'd0, trdb_pkg::PRIV_M);
        // decode, resolve and FIFO push of the last packet
        repeat (8) @(posedge clk_i);
        apb_read(trdb_pkg::ADDR_STATUS, rdata, err);
        compare("prdata STATUS overflow", rdata, 32'h1);
        expect_word(header_word(trdb_pkg::PKT_ADDR, 4'd0, 5'd0, 8'h00), "kept header 0");
        expect_word(32'h4000, "kept address 0");
        expect_word(header_word(trdb_pkg::PKT_ADDR, 4'd0, 5'd0, 8'h00), "kept header 1");
        expect_word(32'h4200, "kept address 1");
        expect_silence(8);
        apb_write(trdb_pkg::ADDR_STATUS, 32'h1);
        apb_read(trdb_pkg::ADDR_STATUS, rdata, err);
        compare("prdata STATUS cleared", rdata, 32'h0);
    endtask

    initial begin
        errors         = 0;
        checks         = 0;
        seed           = 39306;
        instr_i        = '0;
        apb_req_i      = '0;
        packet_ready_i = 1'b0;
        rst_ni         = 1'b0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        registers_access();
        tracing_disabled();
        first_instruction();
        branch_full();
        discontinuity_exception();
        backpressure_overflow();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/trdb_pkg.sv
verilog/trdb_decode.sv
verilog/trdb_branch_map.sv
verilog/trdb_priority.sv
verilog/trdb_packet_emitter.sv
verilog/trdb_apb_regs.sv
verilog/trace_debugger.sv
tests/trace_debugger_assertions.sv
tests/tb_trace_debugger.sv

// File: run.sh
#!/bin/sh
# build and run the trace debugger testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_trace_debugger \
        -f build.f -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1
